// ==== sources.f ====
verilog/exec_pkg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/forwarding_unit.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/exec_pipeline.sv
tests/exec_pipeline_tb.sv

// ==== tests/exec_pipeline_tb.sv ====
module exec_pipeline_tb;

    localparam int DRAIN_LIMIT = 20;
    localparam int LATENCY     = 3;

    typedef struct {
        logic                          valid;
        exec_pkg::alu_op_e             op;
        logic [exec_pkg::REG_SIZE-1:0] rs;
        logic [exec_pkg::REG_SIZE-1:0] rt;
        logic [exec_pkg::REG_SIZE-1:0] rd;
        logic [exec_pkg::IMM_W-1:0]    imm;
        logic [exec_pkg::REG_SIZE-1:0] exp_reg;
        logic [exec_pkg::DATA_W-1:0]   exp_data;
    } step_t;

    logic                          clk;
    logic                          rst_n;
    logic                          issue_valid;
    exec_pkg::alu_op_e             issue_op;
    logic [exec_pkg::REG_SIZE-1:0] issue_rs;
    logic [exec_pkg::REG_SIZE-1:0] issue_rt;
    logic [exec_pkg::REG_SIZE-1:0] issue_rd;
    logic [exec_pkg::IMM_W-1:0]    issue_imm;
    logic                          wb_valid;
    logic [exec_pkg::REG_SIZE-1:0] wb_reg;
    logic [exec_pkg::DATA_W-1:0]   wb_data;

    step_t                         steps[$];
    logic [exec_pkg::REG_SIZE-1:0] exp_regs[$];
    logic [exec_pkg::DATA_W-1:0]   exp_datas[$];
    int                            exp_cycles[$];
    logic [exec_pkg::DATA_W-1:0]   model_regs [exec_pkg::NUM_REGS];
    int                            cycle;
    int                            value_errors;
    int                            other_errors;

    exec_pipeline i_exec_pipeline (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs    (issue_rs),
        .issue_rt    (issue_rt),
        .issue_rd    (issue_rd),
        .issue_imm   (issue_imm),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_reg(input string name, input logic [exec_pkg::REG_SIZE-1:0] actual,
                             input logic [exec_pkg::REG_SIZE-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_data(input string name, input logic [exec_pkg::DATA_W-1:0] actual,
                              input logic [exec_pkg::DATA_W-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
        end
    endtask

    task automatic check_latency(input string name, input int actual, input int expected);
        if (actual != expected) begin
            value_errors++;
            $display("FAILED at %0t: %s = cycle %0d, expected cycle %0d",
                     $time, name, actual, expected);
        end
    endtask

    // Reference semantics of each opcode, in instruction order.
    function automatic logic [15:0] model_result(input exec_pkg::alu_op_e op,
                                                 input logic [15:0] a, input logic [15:0] b,
                                                 input logic [7:0] imm);
        case (op)
            exec_pkg::OP_ADD: return a + b;
            exec_pkg::OP_SUB: return a - b;
            exec_pkg::OP_AND: return a & b;
            exec_pkg::OP_ORR: return a | b;
            exec_pkg::OP_NOT: return ~a;
            exec_pkg::OP_TCP: return 16'h0000 - a;
            exec_pkg::OP_SHL: return {a[14:0], 1'b0};
            exec_pkg::OP_SHR: return {1'b0, a[15:1]};
            exec_pkg::OP_ADI: return a + {{8{imm[7]}}, imm};
            exec_pkg::OP_ORI: return a | {8'h00, imm};
            exec_pkg::OP_LHI: return {imm, 8'h00};
            exec_pkg::OP_LNK: return {8'h00, imm};
            default:          return 16'h0000;
        endcase
    endfunction

    function automatic logic [1:0] model_dest(input exec_pkg::alu_op_e op,
                                              input logic [1:0] rt, input logic [1:0] rd);
        case (op)
            exec_pkg::OP_ADI, exec_pkg::OP_ORI, exec_pkg::OP_LHI: return rt;
            exec_pkg::OP_LNK: return 2'd2;
            default:          return rd;
        endcase
    endfunction

    task automatic add_step(input logic valid, input exec_pkg::alu_op_e op,
                            input logic [1:0] rs, input logic [1:0] rt, input logic [1:0] rd,
                            input logic [7:0] imm, input logic [1:0] exp_reg,
                            input logic [15:0] exp_data);
        step_t s;
        s.valid    = valid;
        s.op       = op;
        s.rs       = rs;
        s.rt       = rt;
        s.rd       = rd;
        s.imm      = imm;
        s.exp_reg  = exp_reg;
        s.exp_data = exp_data;
        steps.push_back(s);
    endtask

    // Columns: valid, op, rs, rt, rd, imm, expected register, expected value.
    task automatic load_table();
        add_step(1, exec_pkg::OP_LHI, 0, 1, 0, 8'h12, 1, 16'h1200);
        add_step(1, exec_pkg::OP_ORI, 1, 1, 0, 8'h34, 1, 16'h1234);
        add_step(1, exec_pkg::OP_LNK, 0, 0, 0, 8'h56, 2, 16'h0056);
        add_step(1, exec_pkg::OP_ADD, 1, 2, 3, 8'h00, 3, 16'h128a);
        add_step(1, exec_pkg::OP_SUB, 3, 1, 0, 8'h00, 0, 16'h0056);
        add_step(1, exec_pkg::OP_AND, 0, 0, 2, 8'h00, 2, 16'h0056);
        add_step(1, exec_pkg::OP_ORR, 2, 3, 1, 8'h00, 1, 16'h12de);
        add_step(1, exec_pkg::OP_NOT, 1, 0, 0, 8'h00, 0, 16'hed21);
        add_step(1, exec_pkg::OP_TCP, 0, 0, 3, 8'h00, 3, 16'h12df);
        add_step(1, exec_pkg::OP_SHL, 3, 0, 3, 8'h00, 3, 16'h25be);
        add_step(1, exec_pkg::OP_SHR, 3, 0, 2, 8'h00, 2, 16'h12df);
        add_step(1, exec_pkg::OP_ADI, 2, 0, 0, 8'hf0, 0, 16'h12cf);
        // A NOP and a bubble that would corrupt r0 if they wrote or forwarded.
        add_step(1, exec_pkg::OP_NOP, 1, 1, 0, 8'h00, 0, 16'h0000);
        add_step(0, exec_pkg::OP_ADD, 1, 1, 0, 8'h00, 0, 16'h0000);
        add_step(1, exec_pkg::OP_ADD, 0, 0, 1, 8'h00, 1, 16'h259e);
        add_step(0, exec_pkg::OP_LNK, 0, 0, 0, 8'hff, 0, 16'h0000);
        add_step(0, exec_pkg::OP_LNK, 0, 0, 0, 8'hff, 0, 16'h0000);
        add_step(1, exec_pkg::OP_ADD, 1, 3, 2, 8'h00, 2, 16'h4b5c);
        add_step(1, exec_pkg::OP_LNK, 0, 0, 0, 8'h11, 2, 16'h0011);
        add_step(1, exec_pkg::OP_LNK, 0, 0, 0, 8'h22, 2, 16'h0022);
        add_step(1, exec_pkg::OP_ADD, 2, 2, 0, 8'h00, 0, 16'h0044);
        add_step(1, exec_pkg::OP_LHI, 0, 3, 0, 8'ha5, 3, 16'ha500);
        add_step(0, exec_pkg::OP_NOP, 0, 0, 0, 8'h00, 0, 16'h0000);
        add_step(1, exec_pkg::OP_SUB, 1, 3, 1, 8'h00, 1, 16'h809e);
        add_step(1, exec_pkg::OP_ADI, 1, 3, 0, 8'h7f, 3, 16'h811d);
    endtask

    // Drives one instruction and runs it through the reference model.
    task automatic issue(input logic valid, input exec_pkg::alu_op_e op,
                         input logic [1:0] rs, input logic [1:0] rt, input logic [1:0] rd,
                         input logic [7:0] imm, output logic writes,
                         output logic [1:0] dest, output logic [15:0] data);
        @(negedge clk);
        issue_valid = valid;
        issue_op    = op;
        issue_rs    = rs;
        issue_rt    = rt;
        issue_rd    = rd;
        issue_imm   = imm;
        writes = valid && (op != exec_pkg::OP_NOP);
        dest   = 2'd0;
        data   = 16'h0000;
        if (writes) begin
            dest = model_dest(op, rt, rd);
            data = model_result(op, model_regs[rs], model_regs[rt], imm);
            model_regs[dest] = data;
        end
    endtask

    task automatic push_expected(input logic [1:0] dest, input logic [15:0] data);
        exp_regs.push_back(dest);
        exp_datas.push_back(data);
        exp_cycles.push_back(cycle + LATENCY);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if ($isunknown(wb_valid)) begin
                other_errors++;
                $display("wb_valid is unknown at time %0t", $time);
            end else if (wb_valid) begin
                if (exp_regs.size() == 0) begin
                    other_errors++;
                    $display("wb_valid went high at time %0t with no result pending", $time);
                end else begin
                    check_latency("wb_valid", cycle, exp_cycles.pop_front());
                    check_reg("wb_reg", wb_reg, exp_regs.pop_front());
                    check_data("wb_data", wb_data, exp_datas.pop_front());
                end
            end
        end
    end

    initial begin
        logic        writes;
        logic [1:0]  dest;
        logic [15:0] data;
        int          waited;

        void'($urandom(32'h5c08_852c));
        cycle        = 0;
        value_errors = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue_op     = exec_pkg::OP_NOP;
        issue_rs     = '0;
        issue_rt     = '0;
        issue_rd     = '0;
        issue_imm    = '0;
        for (int r = 0; r < exec_pkg::NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        load_table();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (steps[i]) begin
            issue(steps[i].valid, steps[i].op, steps[i].rs, steps[i].rt, steps[i].rd,
                  steps[i].imm, writes, dest, data);
            if (writes) begin
                if ((dest !== steps[i].exp_reg) || (data !== steps[i].exp_data)) begin
                    other_errors++;
                    $display("Table row %0d disagrees with the reference model", i);
                end
                push_expected(steps[i].exp_reg, steps[i].exp_data);
            end
        end

        // Random stream with about one bubble in eight.
        for (int n = 0; n < 40; n++) begin
            issue(($urandom_range(7, 0) != 0), exec_pkg::alu_op_e'($urandom_range(12, 0)),
                  $urandom_range(3, 0), $urandom_range(3, 0), $urandom_range(3, 0),
                  $urandom_range(255, 0), writes, dest, data);
            if (writes) begin
                push_expected(dest, data);
            end
        end

        @(negedge clk);
        issue_valid = 1'b0;
        issue_op    = exec_pkg::OP_NOP;

        waited = 0;
        while ((exp_regs.size() != 0) && (waited < DRAIN_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        if (exp_regs.size() != 0) begin
            other_errors++;
            $display("Timed out with %0d results never written back", exp_regs.size());
        end
        // Extra cycles catch a stray write after the last result.
        repeat (LATENCY + 1) @(negedge clk);

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/exec_pipeline.sv ====
module exec_pipeline (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          issue_valid,
    input  exec_pkg::alu_op_e             issue_op,
    input  logic [exec_pkg::REG_SIZE-1:0] issue_rs,
    input  logic [exec_pkg::REG_SIZE-1:0] issue_rt,
    input  logic [exec_pkg::REG_SIZE-1:0] issue_rd,
    input  logic [exec_pkg::IMM_W-1:0]    issue_imm,
    output logic                          wb_valid,
    output logic [exec_pkg::REG_SIZE-1:0] wb_reg,
    output logic [exec_pkg::DATA_W-1:0]   wb_data
);

    logic [exec_pkg::REG_SIZE-1:0] rf_addr_a;
    logic [exec_pkg::REG_SIZE-1:0] rf_addr_b;
    logic [exec_pkg::DATA_W-1:0]   rf_data_a;
    logic [exec_pkg::DATA_W-1:0]   rf_data_b;

    logic                          idex_valid;
    exec_pkg::alu_op_e             idex_op;
    logic [exec_pkg::REG_SIZE-1:0] idex_rs;
    logic [exec_pkg::REG_SIZE-1:0] idex_rt;
    logic [exec_pkg::DATA_W-1:0]   idex_a;
    logic [exec_pkg::DATA_W-1:0]   idex_b;
    logic [exec_pkg::IMM_W-1:0]    idex_imm;
    logic [exec_pkg::REG_SIZE-1:0] idex_dest;
    logic                          idex_reg_write;

    exec_pkg::fwd_sel_e            fwd_a;
    exec_pkg::fwd_sel_e            fwd_b;

    logic                          exmem_reg_write;
    logic [exec_pkg::REG_SIZE-1:0] exmem_dest;
    logic [exec_pkg::DATA_W-1:0]   exmem_data;

    // The MEM/WB register drives the result ports directly.
    register_file i_register_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rf_addr_a),
        .rd_addr_b (rf_addr_b),
        .wr_en     (wb_valid),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b)
    );

    decode_stage i_decode_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_rs       (issue_rs),
        .issue_rt       (issue_rt),
        .issue_rd       (issue_rd),
        .issue_imm      (issue_imm),
        .rf_data_a      (rf_data_a),
        .rf_data_b      (rf_data_b),
        .rf_addr_a      (rf_addr_a),
        .rf_addr_b      (rf_addr_b),
        .idex_valid     (idex_valid),
        .idex_op        (idex_op),
        .idex_rs        (idex_rs),
        .idex_rt        (idex_rt),
        .idex_a         (idex_a),
        .idex_b         (idex_b),
        .idex_imm       (idex_imm),
        .idex_dest      (idex_dest),
        .idex_reg_write (idex_reg_write)
    );

    forwarding_unit i_forwarding_unit (
        .idex_rs         (idex_rs),
        .idex_rt         (idex_rt),
        .exmem_reg_write (exmem_reg_write),
        .exmem_dest      (exmem_dest),
        .memwb_reg_write (wb_valid),
        .memwb_dest      (wb_reg),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b)
    );

    execute_stage i_execute_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .idex_valid      (idex_valid),
        .idex_op         (idex_op),
        .idex_a          (idex_a),
        .idex_b          (idex_b),
        .idex_imm        (idex_imm),
        .idex_dest       (idex_dest),
        .idex_reg_write  (idex_reg_write),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .memwb_data      (wb_data),
        .exmem_reg_write (exmem_reg_write),
        .exmem_dest      (exmem_dest),
        .exmem_data      (exmem_data)
    );

    writeback_stage i_writeback_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .exmem_reg_write (exmem_reg_write),
        .exmem_dest      (exmem_dest),
        .exmem_data      (exmem_data),
        .memwb_reg_write (wb_valid),
        .memwb_dest      (wb_reg),
        .memwb_data      (wb_data)
    );

endmodule

// ==== verilog/writeback_stage.sv ====
module writeback_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          exmem_reg_write,
    input  logic [exec_pkg::REG_SIZE-1:0] exmem_dest,
    input  logic [exec_pkg::DATA_W-1:0]   exmem_data,
    output logic                          memwb_reg_write,
    output logic [exec_pkg::REG_SIZE-1:0] memwb_dest,
    output logic [exec_pkg::DATA_W-1:0]   memwb_data
);

    // No data memory, so MEM only moves the result one stage on.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memwb_reg_write <= 1'b0;
        end else begin
            memwb_reg_write <= exmem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        memwb_dest <= exmem_dest;
        memwb_data <= exmem_data;
    end

endmodule

// ==== verilog/execute_stage.sv ====
module execute_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          idex_valid,
    input  exec_pkg::alu_op_e             idex_op,
    input  logic [exec_pkg::DATA_W-1:0]   idex_a,
    input  logic [exec_pkg::DATA_W-1:0]   idex_b,
    input  logic [exec_pkg::IMM_W-1:0]    idex_imm,
    input  logic [exec_pkg::REG_SIZE-1:0] idex_dest,
    input  logic                          idex_reg_write,
    input  exec_pkg::fwd_sel_e            fwd_a,
    input  exec_pkg::fwd_sel_e            fwd_b,
    input  logic [exec_pkg::DATA_W-1:0]   memwb_data,
    output logic                          exmem_reg_write,
    output logic [exec_pkg::REG_SIZE-1:0] exmem_dest,
    output logic [exec_pkg::DATA_W-1:0]   exmem_data
);

    localparam int EXT_W = exec_pkg::DATA_W - exec_pkg::IMM_W;

    logic [exec_pkg::DATA_W-1:0] op_a;
    logic [exec_pkg::DATA_W-1:0] op_b;
    logic [exec_pkg::DATA_W-1:0] imm_sext;
    logic [exec_pkg::DATA_W-1:0] imm_zext;
    logic [exec_pkg::DATA_W-1:0] imm_high;
    logic [exec_pkg::DATA_W-1:0] alu_result;

    // Operand forward muxes.
    always_comb begin
        case (fwd_a)
            exec_pkg::FWD_MEM: op_a = exmem_data;
            exec_pkg::FWD_WB:  op_a = memwb_data;
            default:           op_a = idex_a;
        endcase
    end

    always_comb begin
        case (fwd_b)
            exec_pkg::FWD_MEM: op_b = exmem_data;
            exec_pkg::FWD_WB:  op_b = memwb_data;
            default:           op_b = idex_b;
        endcase
    end

    assign imm_sext = {{EXT_W{idex_imm[exec_pkg::IMM_W-1]}}, idex_imm};
    assign imm_zext = {{EXT_W{1'b0}}, idex_imm};
    assign imm_high = {idex_imm, {EXT_W{1'b0}}};

    always_comb begin
        case (idex_op)
            exec_pkg::OP_ADD: alu_result = op_a + op_b;
            exec_pkg::OP_SUB: alu_result = op_a - op_b;
            exec_pkg::OP_AND: alu_result = op_a & op_b;
            exec_pkg::OP_ORR: alu_result = op_a | op_b;
            exec_pkg::OP_NOT: alu_result = ~op_a;
            exec_pkg::OP_TCP: alu_result = ~op_a + 1'b1;
            exec_pkg::OP_SHL: alu_result = op_a << 1;
            // Logical shift, zero enters at the top.
            exec_pkg::OP_SHR: alu_result = op_a >> 1;
            exec_pkg::OP_ADI: alu_result = op_a + imm_sext;
            exec_pkg::OP_ORI: alu_result = op_a | imm_zext;
            exec_pkg::OP_LHI: alu_result = imm_high;
            exec_pkg::OP_LNK: alu_result = imm_zext;
            default:          alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exmem_reg_write <= 1'b0;
        end else begin
            exmem_reg_write <= idex_valid && idex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        exmem_dest <= idex_dest;
        exmem_data <= alu_result;
    end

endmodule

// ==== verilog/forwarding_unit.sv ====
module forwarding_unit (
    input  logic [exec_pkg::REG_SIZE-1:0] idex_rs,
    input  logic [exec_pkg::REG_SIZE-1:0] idex_rt,
    input  logic                          exmem_reg_write,
    input  logic [exec_pkg::REG_SIZE-1:0] exmem_dest,
    input  logic                          memwb_reg_write,
    input  logic [exec_pkg::REG_SIZE-1:0] memwb_dest,
    output exec_pkg::fwd_sel_e            fwd_a,
    output exec_pkg::fwd_sel_e            fwd_b
);

    // The newer producer in EX/MEM takes priority over MEM/WB.
    function automatic exec_pkg::fwd_sel_e pick_source(
        input logic [exec_pkg::REG_SIZE-1:0] src
    );
        exec_pkg::fwd_sel_e sel;
        if (exmem_reg_write && (exmem_dest == src)) begin
            sel = exec_pkg::FWD_MEM;
        end else if (memwb_reg_write && (memwb_dest == src)) begin
            sel = exec_pkg::FWD_WB;
        end else begin
            sel = exec_pkg::FWD_NONE;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_source(idex_rs);
        fwd_b = pick_source(idex_rt);
    end

endmodule

// ==== verilog/decode_stage.sv ====
module decode_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          issue_valid,
    input  exec_pkg::alu_op_e             issue_op,
    input  logic [exec_pkg::REG_SIZE-1:0] issue_rs,
    input  logic [exec_pkg::REG_SIZE-1:0] issue_rt,
    input  logic [exec_pkg::REG_SIZE-1:0] issue_rd,
    input  logic [exec_pkg::IMM_W-1:0]    issue_imm,
    input  logic [exec_pkg::DATA_W-1:0]   rf_data_a,
    input  logic [exec_pkg::DATA_W-1:0]   rf_data_b,
    output logic [exec_pkg::REG_SIZE-1:0] rf_addr_a,
    output logic [exec_pkg::REG_SIZE-1:0] rf_addr_b,
    output logic                          idex_valid,
    output exec_pkg::alu_op_e             idex_op,
    output logic [exec_pkg::REG_SIZE-1:0] idex_rs,
    output logic [exec_pkg::REG_SIZE-1:0] idex_rt,
    output logic [exec_pkg::DATA_W-1:0]   idex_a,
    output logic [exec_pkg::DATA_W-1:0]   idex_b,
    output logic [exec_pkg::IMM_W-1:0]    idex_imm,
    output logic [exec_pkg::REG_SIZE-1:0] idex_dest,
    output logic                          idex_reg_write
);

    exec_pkg::dest_sel_e           dest_sel;
    logic [exec_pkg::REG_SIZE-1:0] dest;
    logic                          reg_write;

    assign rf_addr_a = issue_rs;
    assign rf_addr_b = issue_rt;

    // Immediate forms write rt, link writes the fixed link register.
    always_comb begin
        case (issue_op)
            exec_pkg::OP_ADI,
            exec_pkg::OP_ORI,
            exec_pkg::OP_LHI: dest_sel = exec_pkg::DEST_RT;
            exec_pkg::OP_LNK: dest_sel = exec_pkg::DEST_TWO;
            default:          dest_sel = exec_pkg::DEST_RD;
        endcase
    end

    always_comb begin
        case (dest_sel)
            exec_pkg::DEST_RT:  dest = issue_rt;
            exec_pkg::DEST_TWO: dest = exec_pkg::LINK_REG;
            default:            dest = issue_rd;
        endcase
    end

    assign reg_write = issue_valid && (issue_op != exec_pkg::OP_NOP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idex_valid     <= 1'b0;
            idex_op        <= exec_pkg::OP_NOP;
            idex_reg_write <= 1'b0;
        end else begin
            idex_valid     <= issue_valid;
            idex_op        <= issue_op;
            idex_reg_write <= reg_write;
        end
    end

    always_ff @(posedge clk) begin
        idex_rs   <= issue_rs;
        idex_rt   <= issue_rt;
        idex_a    <= rf_data_a;
        idex_b    <= rf_data_b;
        idex_imm  <= issue_imm;
        idex_dest <= dest;
    end

    a_issue_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid |-> (!$isunknown(issue_op) && (issue_op <= exec_pkg::OP_LNK))
    );

endmodule

// ==== verilog/register_file.sv ====
module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [exec_pkg::REG_SIZE-1:0] rd_addr_a,
    input  logic [exec_pkg::REG_SIZE-1:0] rd_addr_b,
    input  logic                          wr_en,
    input  logic [exec_pkg::REG_SIZE-1:0] wr_addr,
    input  logic [exec_pkg::DATA_W-1:0]   wr_data,
    output logic [exec_pkg::DATA_W-1:0]   rd_data_a,
    output logic [exec_pkg::DATA_W-1:0]   rd_data_b
);

    logic [exec_pkg::DATA_W-1:0] regs [exec_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < exec_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-to-read bypass so a retiring result reaches decode in the same cycle.
    always_comb begin
        if (wr_en && (wr_addr == rd_addr_a)) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end
    end

    always_comb begin
        if (wr_en && (wr_addr == rd_addr_b)) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

    // A write with an unknown index would corrupt an unknown register.
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr)
    );

endmodule

// ==== verilog/exec_pkg.sv ====
package exec_pkg;

    // Datapath and register file sizes.
    localparam int DATA_W   = 16;
    localparam int REG_SIZE = 2;
    localparam int NUM_REGS = 4;
    localparam int IMM_W    = 8;

    // Register written by link-type instructions.
    localparam logic [REG_SIZE-1:0] LINK_REG = 2'd2;

    // Opcodes are contiguous, so OP_LNK is the highest legal value.
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_ORR = 4'd4,
        OP_NOT = 4'd5,
        OP_TCP = 4'd6,
        OP_SHL = 4'd7,
        OP_SHR = 4'd8,
        OP_ADI = 4'd9,
        OP_ORI = 4'd10,
        OP_LHI = 4'd11,
        OP_LNK = 4'd12
    } alu_op_e;

    // Instruction field that names the destination register.
    typedef enum logic [1:0] {
        DEST_RD  = 2'b00,
        DEST_RT  = 2'b01,
        DEST_TWO = 2'b10
    } dest_sel_e;

    // Source of an ALU operand.
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_e;

endpackage
